// File: source/bp_pkg.sv
/*
 * Shared definitions for the fetch-side branch prediction subsystem.
 * Widths, table sizes, reset PC, counter states, resolve and
 * prediction structs.
 */
package bp_pkg;

    // Address and table geometry.
    localparam int XLEN           = 32;
    localparam int DIR_INDEX_BITS = 6;                   // Counter table index, PC[7:2].
    localparam int BTB_INDEX_BITS = 4;                   // Target buffer index, PC[5:2].
    localparam int DIR_ENTRIES    = 1 << DIR_INDEX_BITS;
    localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;

    // Fetch PC after reset and the sequential fetch step.
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // Two-bit saturating counter states, taken at weak_taken or above.
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_state_t;

    // Resolved branch from the reorder buffer.
    typedef struct packed {
        logic            valid;                          // One-cycle strobe.
        logic [XLEN-1:0] pc;                             // Branch PC.
        logic            taken;                          // Actual outcome.
        logic [XLEN-1:0] target;                         // Actual target.
        logic            mispredict;                     // Fetch must be redirected.
    } resolve_t;

    // Prediction for the current fetch PC.
    typedef struct packed {
        logic            taken;                          // Counter taken and BTB hit.
        logic [XLEN-1:0] target;                         // Next fetch PC.
    } prediction_t;

endpackage

// File: source/direction_table.sv
/*
 * Table of 2-bit saturating direction counters.
 * Read combinationally by fetch PC, trained by resolved branches.
 */
`timescale 1ns/1ns

module direction_table (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [bp_pkg::XLEN-1:0]  lookup_pc,
    input  logic                     update_valid,
    input  logic                     update_taken,
    input  logic [bp_pkg::XLEN-1:0]  update_pc,
    output logic                     lookup_taken
);
    import bp_pkg::*;

    counter_state_t              counters [DIR_ENTRIES];
    logic [DIR_INDEX_BITS-1:0]   lookup_index;
    logic [DIR_INDEX_BITS-1:0]   update_index;
    counter_state_t              update_state;
    counter_state_t              stepped_state;

    assign lookup_index = lookup_pc[DIR_INDEX_BITS+1:2];
    assign update_index = update_pc[DIR_INDEX_BITS+1:2];

    assign lookup_taken = (counters[lookup_index] >= weak_taken);  // Upper half predicts taken.

    // Saturating step of the entry being trained.
    always_comb begin
        update_state  = counters[update_index];
        stepped_state = update_state;
        if (update_taken) begin
            case (update_state)
                strong_not_taken: stepped_state = weak_not_taken;
                weak_not_taken:   stepped_state = weak_taken;
                weak_taken:       stepped_state = strong_taken;
                default:          stepped_state = strong_taken;  // Saturated.
            endcase
        end else begin
            case (update_state)
                strong_taken:     stepped_state = weak_taken;
                weak_taken:       stepped_state = weak_not_taken;
                weak_not_taken:   stepped_state = strong_not_taken;
                default:          stepped_state = strong_not_taken;  // Saturated.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DIR_ENTRIES; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (update_valid) begin
            counters[update_index] <= stepped_state;
        end
    end

endmodule

// File: source/target_buffer.sv
/*
 * Direct-mapped branch target buffer.
 * Each entry holds a valid bit, the full branch PC as tag and the target.
 */
`timescale 1ns/1ns

module target_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [bp_pkg::XLEN-1:0]  lookup_pc,
    input  logic                     update_valid,
    input  logic                     update_taken,
    input  logic [bp_pkg::XLEN-1:0]  update_pc,
    input  logic [bp_pkg::XLEN-1:0]  update_target,
    output logic                     hit,
    output logic [bp_pkg::XLEN-1:0]  hit_target
);
    import bp_pkg::*;

    // Tag and target stored together per entry.
    typedef struct packed {
        logic [XLEN-1:0] tag;
        logic [XLEN-1:0] target;
    } btb_entry_t;

    logic [BTB_ENTRIES-1:0]      entry_valid;
    btb_entry_t                  entries [BTB_ENTRIES];
    logic [BTB_INDEX_BITS-1:0]   lookup_index;
    logic [BTB_INDEX_BITS-1:0]   update_index;
    logic                        write_en;
    btb_entry_t                  lookup_entry;

    assign lookup_index = lookup_pc[BTB_INDEX_BITS+1:2];
    assign update_index = update_pc[BTB_INDEX_BITS+1:2];
    assign write_en     = update_valid && update_taken;  // Only taken branches allocate.

    assign lookup_entry = entries[lookup_index];
    assign hit          = entry_valid[lookup_index] && (lookup_entry.tag == lookup_pc);
    assign hit_target   = lookup_entry.target;

    // Valid bits, cleared so nothing hits after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (write_en) begin
            entry_valid[update_index] <= 1'b1;
        end
    end

    // Tag and target storage.
    always_ff @(posedge clk) begin
        if (write_en) begin
            entries[update_index].tag    <= update_pc;
            entries[update_index].target <= update_target;
        end
    end

endmodule

// File: source/branch_predictor.sv
/*
 * Branch predictor.
 * Combines the direction counters and the target buffer into one
 * prediction and forwards resolved branches to both tables.
 */
`timescale 1ns/1ns

module branch_predictor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [bp_pkg::XLEN-1:0]  fetch_pc,
    input  bp_pkg::resolve_t         resolve,
    output bp_pkg::prediction_t      prediction
);
    import bp_pkg::*;

    logic            dir_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;

    direction_table u_direction_table (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (fetch_pc),
        .update_valid (resolve.valid),
        .update_taken (resolve.taken),
        .update_pc    (resolve.pc),
        .lookup_taken (dir_taken)
    );

    target_buffer u_target_buffer (
        .clk           (clk),
        .reset         (reset),
        .lookup_pc     (fetch_pc),
        .update_valid  (resolve.valid),
        .update_taken  (resolve.taken),
        .update_pc     (resolve.pc),
        .update_target (resolve.target),
        .hit           (btb_hit),
        .hit_target    (btb_target)
    );

    // Taken needs both a taken counter and a stored target.
    always_comb begin
        prediction.taken = dir_taken && btb_hit;
        if (prediction.taken) begin
            prediction.target = btb_target;
        end else begin
            prediction.target = fetch_pc + PC_STEP;  // Sequential fetch.
        end
    end

endmodule

// File: source/fetch_pc_gen.sv
/*
 * Fetch PC register.
 * Priority is misprediction redirect, then stall, then the prediction.
 */
`timescale 1ns/1ns

module fetch_pc_gen (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  bp_pkg::resolve_t         resolve,
    input  bp_pkg::prediction_t      prediction,
    output logic [bp_pkg::XLEN-1:0]  fetch_pc
);
    import bp_pkg::*;

    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] next_pc;

    assign redirect = resolve.valid && resolve.mispredict;

    // Correct path of the mispredicted branch.
    always_comb begin
        if (resolve.taken) begin
            redirect_pc = resolve.target;
        end else begin
            redirect_pc = resolve.pc + PC_STEP;  // Fall through.
        end
    end

    // Redirect wins over stall.
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (stall) begin
            next_pc = fetch_pc;                  // Hold.
        end else begin
            next_pc = prediction.target;         // Predicted or sequential.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

// File: source/fetch_predict_top.sv
/*
 * Top level of the fetch prediction subsystem.
 * PC generator and branch predictor.
 */
`timescale 1ns/1ns

module fetch_predict_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  bp_pkg::resolve_t         resolve,
    output logic [bp_pkg::XLEN-1:0]  fetch_pc,
    output bp_pkg::prediction_t      prediction
);
    import bp_pkg::*;

    logic [XLEN-1:0] pc;             // Current fetch PC.
    prediction_t     pred;           // Prediction for that PC.

    fetch_pc_gen u_fetch_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .resolve    (resolve),
        .prediction (pred),
        .fetch_pc   (pc)
    );

    branch_predictor u_branch_predictor (
        .clk        (clk),
        .reset      (reset),
        .fetch_pc   (pc),
        .resolve    (resolve),
        .prediction (pred)
    );

    assign fetch_pc   = pc;
    assign prediction = pred;

endmodule

// File: tb/fetch_predict_properties.sv
/*
 * Concurrent assertions on the fetch prediction top level ports,
 * bound into fetch_predict_top.
 */
`timescale 1ns/1ns

module fetch_predict_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     stall,
    input bp_pkg::resolve_t         resolve,
    input logic [bp_pkg::XLEN-1:0]  fetch_pc,
    input bp_pkg::prediction_t      prediction
);
    import bp_pkg::*;

    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    assign redirect    = resolve.valid && resolve.mispredict;
    assign redirect_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;

    reset_pc_loaded: assert property (@(posedge clk) reset |=> (fetch_pc == RESET_PC))
        else $error("fetch_pc is not RESET_PC after reset");

    stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect) |=> $stable(fetch_pc))
        else $error("fetch_pc moved during a stall");

    sequential_target: assert property (@(posedge clk) disable iff (reset)
        !prediction.taken |-> (prediction.target == fetch_pc + 32'd4))
        else $error("not-taken prediction target is not fetch_pc + 4");

    redirect_loads_pc: assert property (@(posedge clk) disable iff (reset)
        redirect |=> (fetch_pc == $past(redirect_pc)))
        else $error("mispredict did not redirect fetch_pc");

endmodule

bind fetch_predict_top fetch_predict_properties u_properties (.*);

// File: tb/fetch_predict_tb.sv
/*
 * Testbench for the fetch prediction top level.
 * Clock, reset, directed and random stimulus, reference model,
 * compare tasks, watchdog and summary.
 */
`timescale 1ns/1ns

module fetch_predict_tb;
    import bp_pkg::*;

    localparam int          CLK_PERIOD     = 100;
    localparam int          RANDOM_CYCLES  = 2000;
    localparam int          PLANNED_CYCLES = RANDOM_CYCLES + 200;  // Plus reset and directed tests.
    localparam int          MARGIN_CYCLES  = 300;
    localparam int unsigned RANDOM_SEED    = 32'hc6ceff6b;

    logic                clk;
    logic                reset;
    logic                stall;
    resolve_t            resolve;
    logic [XLEN-1:0]     fetch_pc;
    prediction_t         prediction;

    // Reference model state.
    int                  model_counter [DIR_ENTRIES];  // 0 strong not taken up to 3.
    logic                model_valid   [BTB_ENTRIES];
    logic [XLEN-1:0]     model_tag     [BTB_ENTRIES];
    logic [XLEN-1:0]     model_target  [BTB_ENTRIES];
    logic [XLEN-1:0]     model_pc;

    int                  pass_count = 0;
    int                  fail_count = 0;
    int                  test_num   = 0;
    int                  test_start_total = 0;
    int                  test_start_fail  = 0;

    fetch_predict_top DUT (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .resolve    (resolve),
        .fetch_pc   (fetch_pc),
        .prediction (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected prediction for a fetch PC from the model tables.
    function automatic prediction_t predict(logic [XLEN-1:0] pc);
        prediction_t p;
        int          di;
        int          bi;
        di       = pc[DIR_INDEX_BITS+1:2];
        bi       = pc[BTB_INDEX_BITS+1:2];
        p.taken  = (model_counter[di] >= 2) && model_valid[bi] && (model_tag[bi] == pc);
        p.target = p.taken ? model_target[bi] : pc + 32'd4;
        return p;
    endfunction

    // One edge of the model. Lookup uses the contents before training.
    task automatic model_step();
        prediction_t p;
        int          di;
        int          bi;
        if (reset) begin
            model_pc = RESET_PC;
            for (int i = 0; i < DIR_ENTRIES; i++) model_counter[i] = 1;
            for (int i = 0; i < BTB_ENTRIES; i++) model_valid[i] = 1'b0;
        end else begin
            p = predict(model_pc);
            if (resolve.valid && resolve.mispredict) begin
                model_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;
            end else if (!stall) begin
                model_pc = p.target;
            end
            if (resolve.valid) begin
                di = resolve.pc[DIR_INDEX_BITS+1:2];
                bi = resolve.pc[BTB_INDEX_BITS+1:2];
                if (resolve.taken) begin
                    if (model_counter[di] < 3) model_counter[di]++;
                    model_valid[bi]  = 1'b1;
                    model_tag[bi]    = resolve.pc;
                    model_target[bi] = resolve.target;
                end else if (model_counter[di] > 0) begin
                    model_counter[di]--;
                end
            end
        end
    endtask

    task automatic check_pc(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_prediction(string name, prediction_t expected, prediction_t actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) model_step();    // Sees inputs before this edge's drives.

    // Compare against the model once the edge has settled.
    always @(negedge clk) begin
        if (!reset) begin
            check_pc("fetch_pc", model_pc, fetch_pc);
            check_prediction("prediction", predict(model_pc), prediction);
        end
    end

    function automatic resolve_t make_resolve(logic v, logic [XLEN-1:0] pc, logic tk,
                                              logic [XLEN-1:0] tgt, logic mis);
        resolve_t r;
        r.valid      = v;
        r.pc         = pc;
        r.taken      = tk;
        r.target     = tgt;
        r.mispredict = mis;
        return r;
    endfunction

    task automatic drive_cycle(logic st, resolve_t r);
        @(posedge clk);
        stall   <= st;
        resolve <= r;
    endtask

    // Resolves a branch several times under stall, then lets it settle.
    task automatic train_branch(logic [XLEN-1:0] pc, logic tk, logic [XLEN-1:0] tgt, int n);
        repeat (n) drive_cycle(1'b1, make_resolve(1'b1, pc, tk, tgt, 1'b0));
        drive_cycle(1'b1, '0);
        @(negedge clk);
    endtask

    // Mispredicted taken branch at a spare PC sends fetch to a new address.
    task automatic redirect_fetch(logic [XLEN-1:0] tgt);
        drive_cycle(1'b1, make_resolve(1'b1, 32'h0000_3008, 1'b1, tgt, 1'b1));
        drive_cycle(1'b1, '0);
        @(negedge clk);
    endtask

    task automatic wait_for_pc(logic [XLEN-1:0] pc, int limit, output logic found);
        found = 1'b0;
        for (int i = 0; i < limit && !found; i++) begin
            @(negedge clk);
            if (fetch_pc === pc) found = 1'b1;
        end
        if (!found) begin
            fail_count++;
            $display("Fetch PC never reached %h within %0d cycles", pc, limit);
        end
    endtask

    task automatic finish_test(string name);
        test_num++;
        $display("test %0d %-24s %0d checks, %0d errors", test_num, name,
                 pass_count + fail_count - test_start_total, fail_count - test_start_fail);
        test_start_total = pass_count + fail_count;
        test_start_fail  = fail_count;
    endtask

    task automatic run_random(int cycles);
        resolve_t r;
        logic     st;
        for (int i = 0; i < cycles; i++) begin
            st = ($urandom % 4) == 0;
            r  = make_resolve(($urandom % 3) == 0, 32'h1000 + (($urandom % 64) << 2),
                              $urandom % 2, 32'h1000 + (($urandom % 64) << 2),
                              ($urandom % 8) == 0);
            drive_cycle(st, r);
        end
        drive_cycle(1'b0, '0);
        @(negedge clk);
    endtask

    initial begin
        logic found;
        void'($urandom(RANDOM_SEED));
        reset   = 1'b1;
        stall   = 1'b0;
        resolve = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Sequential fetch from the reset PC.
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_pc("fetch_pc", RESET_PC + 4 * i, fetch_pc);
            check_prediction("prediction", {1'b0, RESET_PC + 4 * (i + 1)}, prediction);
        end
        finish_test("sequential fetch");

        // Train a branch ahead of fetch, then follow it.
        drive_cycle(1'b0, make_resolve(1'b1, 32'h0000_1100, 1'b1, 32'h0000_1400, 1'b0));
        drive_cycle(1'b0, make_resolve(1'b1, 32'h0000_1100, 1'b1, 32'h0000_1400, 1'b0));
        drive_cycle(1'b0, '0);
        wait_for_pc(32'h0000_1100, 100, found);
        if (found) begin
            check_prediction("prediction", {1'b1, 32'h0000_1400}, prediction);
            @(negedge clk);
            check_pc("fetch_pc", 32'h0000_1400, fetch_pc);
        end
        finish_test("taken branch follow");

        // Counter saturation, fetch parked at 0x2040.
        redirect_fetch(32'h0000_2040);
        check_pc("fetch_pc", 32'h0000_2040, fetch_pc);
        train_branch(32'h0000_2040, 1'b1, 32'h0000_2300, 4);
        check_prediction("prediction", {1'b1, 32'h0000_2300}, prediction);
        train_branch(32'h0000_2040, 1'b0, 32'h0, 1);
        check_prediction("prediction", {1'b1, 32'h0000_2300}, prediction);  // Still weak taken.
        train_branch(32'h0000_2040, 1'b0, 32'h0, 3);
        check_prediction("prediction", {1'b0, 32'h0000_2044}, prediction);
        train_branch(32'h0000_2040, 1'b1, 32'h0000_2300, 2);
        check_prediction("prediction", {1'b1, 32'h0000_2300}, prediction);
        finish_test("counter saturation");

        // Same BTB index, different tag.
        train_branch(32'h0000_2080, 1'b1, 32'h0000_2500, 2);
        check_prediction("prediction", {1'b0, 32'h0000_2044}, prediction);
        redirect_fetch(32'h0000_2080);
        check_pc("fetch_pc", 32'h0000_2080, fetch_pc);
        check_prediction("prediction", {1'b1, 32'h0000_2500}, prediction);
        finish_test("target aliasing");

        // Redirects win over stall, plain stall holds.
        drive_cycle(1'b1, make_resolve(1'b1, 32'h0000_2100, 1'b1, 32'h0000_2600, 1'b1));
        drive_cycle(1'b1, '0);
        @(negedge clk);
        check_pc("fetch_pc", 32'h0000_2600, fetch_pc);
        repeat (3) begin
            drive_cycle(1'b1, '0);
            @(negedge clk);
            check_pc("fetch_pc", 32'h0000_2600, fetch_pc);
        end
        drive_cycle(1'b1, make_resolve(1'b1, 32'h0000_2704, 1'b0, 32'h0, 1'b1));
        drive_cycle(1'b1, '0);
        @(negedge clk);
        check_pc("fetch_pc", 32'h0000_2708, fetch_pc);  // Not taken, falls through.
        drive_cycle(1'b0, '0);
        finish_test("stall and redirect");

        run_random(RANDOM_CYCLES);
        finish_test("random mix");

        $display("summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #((PLANNED_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 PLANNED_CYCLES + MARGIN_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: all.f
source/bp_pkg.sv
source/direction_table.sv
source/target_buffer.sv
source/branch_predictor.sv
source/fetch_pc_gen.sv
source/fetch_predict_top.sv
tb/fetch_predict_properties.sv
tb/fetch_predict_tb.sv

// File: Bender.yml
package:
  name: fetch_predict

dependencies: {}

sources:
  # Design, package first.
  - source/bp_pkg.sv
  - source/direction_table.sv
  - source/target_buffer.sv
  - source/branch_predictor.sv
  - source/fetch_pc_gen.sv
  - source/fetch_predict_top.sv

  # Testbench with bound assertions, top module fetch_predict_tb.
  - target: test
    files:
      - tb/fetch_predict_properties.sv
      - tb/fetch_predict_tb.sv
